// ==== logic/dec_pkg.sv ====
// Shared decode definitions: instruction field types, opcode codes,
// register number constants, the decode bundle struct and an opcode class helper
package dec_pkg;

	// ========================================================================
	// Widths and field types
	// ========================================================================

	// Width of the immediate field and of a data value
	localparam int IMM_W   = 23;
	localparam int VALUE_W = 64;

	// Raw 48-bit instruction word as it leaves fetch
	typedef logic [47:0] instr_t;

	// Opcode lives in the low seven bits of every format
	typedef logic [6:0] opcode_t;

	// Architectural register number, wide enough for GPRs and mask registers
	typedef logic [7:0] aregno_t;

	// 64-bit data value, the immediate is widened to this
	typedef logic [VALUE_W-1:0] value_t;

	// Register field as encoded in the instruction (six bits)
	typedef logic [5:0] regfld_t;

	// Two-bit mask register selector
	typedef logic [1:0] maskfld_t;

	// Immediate-shift amount, zero extended when used
	typedef logic [5:0] shamt_t;

	// Raw immediate field taken from the top of the word
	typedef logic [IMM_W-1:0] immfld_t;

	// ========================================================================
	// Opcodes and register numbers
	// ========================================================================

	// Any code not listed here decodes the same as OP_NOP
	localparam opcode_t OP_NOP   = 7'd0;
	localparam opcode_t OP_R2    = 7'd2;
	localparam opcode_t OP_ADDI  = 7'd4;
	localparam opcode_t OP_SUBFI = 7'd5;
	localparam opcode_t OP_MULI  = 7'd6;
	localparam opcode_t OP_ANDI  = 7'd8;
	localparam opcode_t OP_ORI   = 7'd9;
	localparam opcode_t OP_EORI  = 7'd10;
	localparam opcode_t OP_CMPI  = 7'd11;
	localparam opcode_t OP_SHIFT = 7'd16;
	localparam opcode_t OP_LOAD  = 7'd64;
	localparam opcode_t OP_STORE = 7'd80;

	// Register 0 stands in for every unused operand slot
	localparam aregno_t REG_ZERO = 8'd0;

	// Mask registers are 48..51, and 48 enables all lanes
	localparam aregno_t REG_MASK_BASE = 8'd48;

	// Decode bundle handed on to rename, one per accepted instruction
	typedef struct packed {
		logic    valid;
		opcode_t opcode;
		aregno_t rt;
		aregno_t ra;
		aregno_t rb;
		aregno_t rc;
		aregno_t rm;
		logic    has_imm;
		value_t  imm;
	} decode_bus_t;

	// True for the arithmetic and logic opcodes that carry a 23-bit immediate
	function automatic logic imm_alu_op(input opcode_t op);
		case (op)
		OP_ADDI, OP_SUBFI, OP_ANDI, OP_ORI, OP_EORI, OP_CMPI, OP_MULI:
			imm_alu_op = 1'b1;
		default:
			imm_alu_op = 1'b0;
		endcase
	endfunction

endpackage

// ==== logic/decode_rm.sv ====
// Mask register decoder for the Rm operand
`timescale 1ns/10ps

module decode_rm
	import dec_pkg::*;
(
	input  instr_t  instr,
	output aregno_t rm
);

	opcode_t  op;
	maskfld_t mask_imm;
	maskfld_t mask_reg;

	// Immediate forms have no Rb, so bits 23:22 are free to hold the mask
	assign op       = instr[6:0];
	assign mask_imm = instr[23:22];
	// Register forms keep the mask up above the Rc field
	assign mask_reg = instr[40:39];

	always_comb
	begin
		// Default mask 48 turns on every lane
		rm = REG_MASK_BASE;
		if (imm_alu_op(op))
		begin
			rm = REG_MASK_BASE + aregno_t'(mask_imm);
		end
		else if (op == OP_R2 || op == OP_SHIFT)
		begin
			rm = REG_MASK_BASE + aregno_t'(mask_reg);
		end
		// Loads, stores and NOP-class codes keep the all-lanes mask
	end

endmodule

// ==== logic/decode_regs.sv ====
// Target and source register decoder for Rt, Ra, Rb and Rc
`timescale 1ns/10ps

module decode_regs
	import dec_pkg::*;
(
	input  instr_t  instr,
	output aregno_t rt,
	output aregno_t ra,
	output aregno_t rb,
	output aregno_t rc
);

	opcode_t op;
	regfld_t fld_rt;
	regfld_t fld_ra;
	regfld_t fld_rb;
	regfld_t fld_rc;
	logic    shift_imm;

	// ========================================================================
	// Raw fields, the same positions in every format
	// ========================================================================

	assign op     = instr[6:0];
	assign fld_rt = instr[12:7];
	assign fld_ra = instr[18:13];
	assign fld_rb = instr[24:19];
	assign fld_rc = instr[30:25];

	// Set when a shift takes its amount from the word instead of from Rb
	assign shift_imm = instr[31];

	// ========================================================================
	// Operand selection
	// ========================================================================

	// Every slot starts as register 0 so rename sees no false dependence
	// on a field that the opcode does not actually read or write
	always_comb
	begin
		rt = REG_ZERO;
		ra = REG_ZERO;
		rb = REG_ZERO;
		rc = REG_ZERO;
		if (imm_alu_op(op) || op == OP_LOAD)
		begin
			// Immediate ops and loads: one destination and one source
			rt = aregno_t'(fld_rt);
			ra = aregno_t'(fld_ra);
		end
		else if (op == OP_R2)
		begin
			// Three-source register form
			rt = aregno_t'(fld_rt);
			ra = aregno_t'(fld_ra);
			rb = aregno_t'(fld_rb);
			rc = aregno_t'(fld_rc);
		end
		else if (op == OP_SHIFT)
		begin
			rt = aregno_t'(fld_rt);
			ra = aregno_t'(fld_ra);
			// Bits 30:25 hold the shift amount when bit 31 is set
			if (!shift_imm)
				rb = aregno_t'(fld_rb);
		end
		else if (op == OP_STORE)
		begin
			// Stores write no register, Rb carries the store data
			ra = aregno_t'(fld_ra);
			rb = aregno_t'(fld_rb);
		end
	end

endmodule

// ==== logic/decode_imm.sv ====
// Immediate extractor: sign-extended 23-bit field or zero-extended shift amount
`timescale 1ns/10ps

module decode_imm
	import dec_pkg::*;
(
	input  instr_t instr,
	output logic   has_imm,
	output value_t imm
);

	opcode_t op;
	immfld_t imm_fld;
	shamt_t  shamt;
	logic    shift_imm;
	value_t  imm_sext;
	value_t  shamt_zext;

	assign op = instr[6:0];

	// The 23-bit immediate sits at the top of the word
	assign imm_fld = instr[47:25];

	// Shift amount shares bits with Rc, flagged by bit 31
	assign shamt     = instr[30:25];
	assign shift_imm = instr[31];

	// ========================================================================
	// Widening
	// ========================================================================

	// Replicate the sign bit across the upper 41 bits
	assign imm_sext = {{(VALUE_W-IMM_W){imm_fld[IMM_W-1]}}, imm_fld};

	// Shift counts are never negative
	assign shamt_zext = value_t'(shamt);

	always_comb
	begin
		has_imm = 1'b0;
		imm     = '0;
		if (imm_alu_op(op) || op == OP_LOAD || op == OP_STORE)
		begin
			// Memory ops use the immediate as an address displacement
			has_imm = 1'b1;
			imm     = imm_sext;
		end
		else if (op == OP_SHIFT && shift_imm)
		begin
			has_imm = 1'b1;
			imm     = shamt_zext;
		end
		// R2, register shifts and NOP-class codes leave imm at zero
	end

endmodule

// ==== logic/decode_stage.sv ====
// Decode stage top: three operand decoders and the registered decode bundle
`timescale 1ns/10ps

module decode_stage
	import dec_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        flush,
	input  logic        valid_in,
	input  instr_t      instr,
	output decode_bus_t dec
);

	aregno_t     rm;
	aregno_t     rt;
	aregno_t     ra;
	aregno_t     rb;
	aregno_t     rc;
	logic        has_imm;
	value_t      imm;
	decode_bus_t dec_next;

	// ========================================================================
	// Combinational decoders
	// ========================================================================

	decode_rm i_decode_rm (
		.instr (instr),
		.rm    (rm)
	);

	decode_regs i_decode_regs (
		.instr (instr),
		.rt    (rt),
		.ra    (ra),
		.rb    (rb),
		.rc    (rc)
	);

	decode_imm i_decode_imm (
		.instr   (instr),
		.has_imm (has_imm),
		.imm     (imm)
	);

	// Gather everything into one bundle before the register
	always_comb
	begin
		dec_next.opcode  = instr[6:0];
		dec_next.rt      = rt;
		dec_next.ra      = ra;
		dec_next.rb      = rb;
		dec_next.rc      = rc;
		dec_next.rm      = rm;
		dec_next.has_imm = has_imm;
		dec_next.imm     = imm;
		// A flush in the same cycle kills the slot regardless of valid_in
		dec_next.valid   = valid_in & ~flush;
	end

	// ========================================================================
	// Pipeline register
	// ========================================================================

	// The stage never stalls, so the bundle is loaded on every edge;
	// data fields follow the input even when the slot is not valid
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			dec <= '0;
		else
			dec <= dec_next;
	end

endmodule

// ==== test/tb_decode_stage.sv ====
// Testbench for the decode stage that reads the stim file, drives the DUT on
// falling edges and checks each registered bundle one cycle later
`timescale 1ns/10ps

module tb_decode_stage
	import dec_pkg::*;
();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_GAP      = 3;
	localparam int SEED         = 50;

	// One driven slot and the bundle it should produce
	// Group 0 marks an idle slot
	typedef struct packed {
		logic [3:0]  grp;
		logic        flush;
		logic        valid;
		instr_t      instr;
		decode_bus_t exp;
	} slot_t;

	logic        clk;
	logic        rst_n;
	logic        flush;
	logic        valid_in;
	instr_t      instr;
	decode_bus_t dec;

	slot_t stim_q[$];
	slot_t pend_q[$];
	bit    loaded;
	bit    stim_ok;
	int    n_lines;
	int    limit_cycles;
	int    errors;
	int    checks;
	int    cur_grp;
	int    grp_lines;
	int    grp_errs;

	decode_stage i_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.flush    (flush),
		.valid_in (valid_in),
		.instr    (instr),
		.dec      (dec)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ========================================================================
	// Checking helpers
	// ========================================================================

	function automatic string group_name(input int g);
		case (g)
		1: group_name = "reset";
		2: group_name = "mask decode";
		3: group_name = "register fields";
		4: group_name = "immediates";
		default: group_name = "timing and flush";
		endcase
	endfunction

	task automatic compare_field(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
			grp_errs++;
		end
	endtask

	// Prints the summary of the group that just ended
	task automatic finish_group();
		if (cur_grp != 0)
		begin
			$display("Group %0d, %s: %0d slots, %0d errors", cur_grp,
				group_name(cur_grp), grp_lines, grp_errs);
			grp_lines = 0;
			grp_errs  = 0;
		end
	endtask

	task automatic check_slot(input slot_t s);
		if (s.grp != 0 && s.grp != cur_grp)
		begin
			finish_group();
			cur_grp = s.grp;
		end
		if (s.grp == 0)
			compare_field("valid in idle slot", dec.valid, 1'b0);
		else
		begin
			grp_lines++;
			compare_field("valid", dec.valid, s.exp.valid);
			compare_field("opcode", dec.opcode, s.exp.opcode);
			compare_field("rt", dec.rt, s.exp.rt);
			compare_field("ra", dec.ra, s.exp.ra);
			compare_field("rb", dec.rb, s.exp.rb);
			compare_field("rc", dec.rc, s.exp.rc);
			compare_field("rm", dec.rm, s.exp.rm);
			compare_field("has_imm", dec.has_imm, s.exp.has_imm);
			compare_field("imm", dec.imm, s.exp.imm);
		end
	endtask

	// ========================================================================
	// Stimulus
	// ========================================================================

	task automatic read_stim(output bit ok);
		int               fd;
		int               n;
		int               line_no;
		int               f_grp, f_flush, f_valid, f_evalid, f_has;
		logic [7:0]       f_op, f_rt, f_ra, f_rb, f_rc, f_rm;
		logic [47:0]      f_instr;
		logic [63:0]      f_imm;
		logic [8*256-1:0] line;
		slot_t            s;
		ok      = 1'b1;
		line_no = 0;
		line    = '0;
		fd      = $fopen("test/decode_stim.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the stim file test/decode_stim.txt");
			ok = 1'b0;
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				line_no++;
				n = $sscanf(line, "%d %d %d %h %d %h %h %h %h %h %h %d %h", f_grp,
					f_flush, f_valid, f_instr, f_evalid, f_op, f_rt, f_ra, f_rb, f_rc,
					f_rm, f_has, f_imm);
				// Comment and blank lines give no fields at all
				if (n == 13)
				begin
					s = '{f_grp[3:0], f_flush[0], f_valid[0], f_instr, '{f_evalid[0],
						f_op[6:0], f_rt, f_ra, f_rb, f_rc, f_rm, f_has[0], f_imm}};
					stim_q.push_back(s);
				end
				else if (n > 0)
				begin
					$display("Line %0d of the stim file is malformed", line_no);
					ok = 1'b0;
				end
				line = '0;
			end
			$fclose(fd);
			if (ok && stim_q.size() == 0)
			begin
				$display("The stim file holds no test lines");
				ok = 1'b0;
			end
		end
	endtask

	// Drives on the falling edge and queues the slot for the next falling edge
	task automatic drive_slot(input slot_t s);
		flush    = s.flush;
		valid_in = s.valid;
		instr    = s.instr;
		pend_q.push_back(s);
	endtask

	task automatic next_cycle();
		slot_t s;
		@(negedge clk);
		if (pend_q.size() > 0)
		begin
			s = pend_q.pop_front();
			check_slot(s);
		end
	endtask

	task automatic run_stim();
		int    gap;
		slot_t idle;
		for (int i = 0; i < stim_q.size(); i++)
		begin
			// Timing lines run back to back
			gap = (stim_q[i].grp == 5) ? 0 : $urandom % (MAX_GAP + 1);
			repeat (gap)
			begin
				idle       = '0;
				idle.instr = instr;
				drive_slot(idle);
				next_cycle();
			end
			drive_slot(stim_q[i]);
			next_cycle();
		end
		// The slot after the last line must come out empty
		idle       = '0;
		idle.instr = instr;
		drive_slot(idle);
		next_cycle();
		finish_group();
	endtask

	// ========================================================================
	// Main sequence and watchdog
	// ========================================================================

	initial
	begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		flush     = 1'b0;
		// Valid is held high through reset so only the reset can clear the bundle
		valid_in  = 1'b1;
		instr     = '0;
		loaded    = 1'b0;
		errors    = 0;
		checks    = 0;
		grp_lines = 0;
		grp_errs  = 0;
		void'($urandom(SEED));
		read_stim(stim_ok);
		if (!stim_ok)
		begin
			$display("Verification failed");
			$finish;
		end
		else
		begin
			n_lines      = stim_q.size();
			limit_cycles = n_lines * (MAX_GAP + 1) + RESET_CYCLES + 20;
			loaded       = 1'b1;
			// Bundle stays cleared for every edge that sees reset
			cur_grp = 1;
			repeat (RESET_CYCLES)
			begin
				@(negedge clk);
				grp_lines++;
				compare_field("valid during reset", dec.valid, 1'b0);
				compare_field("rm during reset", dec.rm, 8'd0);
			end
			rst_n = 1'b1;
			finish_group();
			cur_grp = 0;
			run_stim();
			$display("Field checks: %0d, mismatches: %0d", checks, errors);
			if (errors == 0)
				$display("Verification passed");
			else
				$display("Verification failed");
			$finish;
		end
	end

	initial
	begin
		wait (loaded);
		#(limit_cycles * CLK_PERIOD);
		$display("Timeout: the run did not end within %0d cycles", limit_cycles);
		$display("Verification failed");
		$finish;
	end

endmodule

// ==== test/decode_stim.txt ====
# grp flush valid instr exp_valid opcode rt ra rb rc rm has_imm imm
# grp, flush, valid, exp_valid and has_imm are decimal, the rest is hex
# Mask decode
2 0 1 000020804084 1 04 01 02 00 00 32 1 0000000000000010
2 0 1 000002C10389 1 09 07 08 00 00 33 1 0000000000000001
2 0 1 00000A40818B 1 0B 03 04 00 00 31 1 0000000000000005
2 0 1 01001A616502 1 02 0A 0B 0C 0D 32 0 0000000000000000
2 0 1 01800030A210 1 10 04 05 06 00 33 0 0000000000000000
2 0 1 018000C12140 1 40 02 09 00 00 30 1 000000000000C000
2 0 1 018000C0C280 1 00 00 00 00 00 30 0 0000000000000000
2 0 1 0000000000FF 1 7F 00 00 00 00 30 0 0000000000000000
# Register fields
3 0 1 FFFFFFE063D0 1 50 00 03 3C 00 30 1 FFFFFFFFFFFFFFFF
3 0 1 0080D4AC0F90 1 10 1F 20 00 00 31 1 000000000000002A
3 0 1 00007FFFFF82 1 02 3F 3F 3F 3F 30 0 0000000000000000
3 0 1 0002013E1085 1 05 21 30 00 00 30 1 0000000000000100
# Immediates
4 0 1 800000002088 1 08 01 01 00 00 30 1 FFFFFFFFFFC00000
4 0 1 7FFFFE00010A 1 0A 02 00 00 00 30 1 00000000003FFFFF
4 0 1 FFFFFC808186 1 06 03 04 00 00 32 1 FFFFFFFFFFFFFFFE
4 0 1 FE00FE014010 1 10 00 0A 00 00 30 1 000000000000003F
4 0 1 FFFFFE000000 1 00 00 00 00 00 30 0 0000000000000000
# Timing and flush, driven back to back
5 0 1 000006004084 1 04 01 02 00 00 30 1 0000000000000003
5 0 1 000008006109 1 09 02 03 00 00 30 1 0000000000000004
5 1 1 00000A00818A 0 0A 03 04 00 00 30 1 0000000000000005
5 0 0 00000C00A208 0 08 04 05 00 00 30 1 0000000000000006
5 1 0 00000E00C28B 0 0B 05 06 00 00 30 1 0000000000000007
5 0 1 00001240E302 1 02 06 07 08 09 30 0 0000000000000000
5 0 1 FFFFFE410385 1 05 07 08 00 00 31 1 FFFFFFFFFFFFFFFF

// ==== sim.f ====
logic/dec_pkg.sv
logic/decode_rm.sv
logic/decode_regs.sv
logic/decode_imm.sv
logic/decode_stage.sv
test/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - logic/dec_pkg.sv
  - logic/decode_rm.sv
  - logic/decode_regs.sv
  - logic/decode_imm.sv
  - logic/decode_stage.sv
  - target: test
    files:
      - test/tb_decode_stage.sv
